// File: mext_pkg.sv
package mext_pkg;

  // operand and result word
  typedef logic [31:0] word_t;

  // funct3 field of an OP instruction with funct7 = 0000001
  typedef logic [2:0] funct3_t;

  localparam funct3_t F3_MUL    = 3'd0;
  localparam funct3_t F3_MULH   = 3'd1;
  localparam funct3_t F3_MULHSU = 3'd2;
  localparam funct3_t F3_MULHU  = 3'd3;
  localparam funct3_t F3_DIV    = 3'd4;
  localparam funct3_t F3_DIVU   = 3'd5;
  localparam funct3_t F3_REM    = 3'd6;
  localparam funct3_t F3_REMU   = 3'd7;

  // one-hot operation flags
  typedef struct packed {
    logic mul;
    logic mulh;
    logic mulhsu;
    logic mulhu;
  } mul_op_type;

  typedef struct packed {
    logic div;
    logic divu;
    logic rem;
    logic remu;
  } div_op_type;

  typedef struct packed {
    logic enable;
    mul_op_type op;
    word_t rdata1;
    word_t rdata2;
  } mul_in_type;

  typedef struct packed {
    logic ready;
    word_t result;
  } mul_out_type;

  typedef struct packed {
    logic enable;
    div_op_type op;
    word_t rdata1;
    word_t rdata2;
  } div_in_type;

  typedef struct packed {
    logic ready;
    word_t result;
  } div_out_type;

  // state of the shift-and-add multiplier
  typedef struct packed {
    logic [5:0] counter;
    logic [32:0] op1;
    logic [32:0] op2;
    mul_op_type op;
    logic op1_signed;
    logic op2_signed;
    logic negativ;
    logic op1_neg;
    logic mul;
    logic [64:0] result;
  } mul_reg_type;

  localparam mul_reg_type init_mul_reg = '0;

  typedef enum logic [1:0] {
    idle,
    busy_mul,
    busy_div,
    finish
  } ctrl_state_t;

endpackage

// File: mul.sv
`timescale 1ns/1ns

module mul #(
  parameter int PERFORMANCE = 1
) (
  input  logic                  rst,
  input  logic                  clk,
  input  mext_pkg::mul_in_type  mul_in,
  output mext_pkg::mul_out_type mul_out
);

  if (PERFORMANCE == 0) begin : g_small

    mext_pkg::mul_reg_type r;
    mext_pkg::mul_reg_type rin;
    mext_pkg::mul_reg_type v;
    logic [5:0] lz;
    logic op2_neg;

    always_comb begin
      v = r;
      lz = 6'd32;
      op2_neg = 1'b0;
      mul_out = '0;
      case (r.counter)
        6'd0: begin
          if (mul_in.enable) begin
            v.op = mul_in.op;
            v.op1_signed = mul_in.op.mul | mul_in.op.mulh | mul_in.op.mulhsu;
            v.op2_signed = mul_in.op.mul | mul_in.op.mulh;
            v.mul = |mul_in.op;
            v.op1_neg = v.op1_signed & mul_in.rdata1[31];
            op2_neg = v.op2_signed & mul_in.rdata2[31];
            v.negativ = v.op1_neg ^ op2_neg;
            // magnitudes, bit 32 stays clear
            v.op1 = {1'b0, v.op1_neg ? -mul_in.rdata1 : mul_in.rdata1};
            v.op2 = {1'b0, op2_neg ? -mul_in.rdata2 : mul_in.rdata2};
            v.result = '0;
            // leading zeros of op1 magnitude
            for (int i = 0; i < 32; i++) begin
              if (v.op1[i]) begin
                lz = 6'(31 - i);
              end
            end
            // skip straight to the first set bit
            v.counter = lz + 6'd1;
          end
        end
        6'd33: begin
          if (r.mul && r.negativ) begin
            v.result = -r.result;
          end
          v.counter = 6'd0;
          mul_out.ready = 1'b1;
          if (r.op.mul) begin
            mul_out.result = v.result[31:0];
          end else begin
            mul_out.result = v.result[63:32];
          end
        end
        default: begin
          // msb first, one bit of op1 per cycle
          if (r.mul) begin
            v.result = {r.result[63:0], 1'b0};
            if (r.op1[32 - r.counter]) begin
              v.result = v.result + {32'b0, r.op2};
            end
          end
          v.counter = r.counter + 6'd1;
        end
      endcase
      rin = v;
    end

    always_ff @(posedge clk) begin
      if (!rst) begin
        r <= mext_pkg::init_mul_reg;
      end else begin
        r <= rin;
      end
    end

  end else begin : g_fast

    logic signed [32:0] op1;
    logic signed [32:0] op2;
    logic signed [65:0] product;
    logic op1_signed;
    logic op2_signed;

    always_comb begin
      op1_signed = mul_in.op.mul | mul_in.op.mulh | mul_in.op.mulhsu;
      op2_signed = mul_in.op.mul | mul_in.op.mulh;
      // 33-bit operands cover both signed and unsigned
      op1 = {op1_signed & mul_in.rdata1[31], mul_in.rdata1};
      op2 = {op2_signed & mul_in.rdata2[31], mul_in.rdata2};
      product = op1 * op2;
      if (mul_in.op.mul) begin
        mul_out.result = product[31:0];
      end else begin
        mul_out.result = product[63:32];
      end
      mul_out.ready = mul_in.enable;
    end

  end

endmodule

// File: div.sv
`timescale 1ns/1ns

module div (
  input  logic                  rst,
  input  logic                  clk,
  input  mext_pkg::div_in_type  div_in,
  output mext_pkg::div_out_type div_out
);

  typedef struct packed {
    logic [5:0] counter;
    logic early;
    mext_pkg::div_op_type op;
    logic q_neg;
    logic r_neg;
    mext_pkg::word_t divisor;
    mext_pkg::word_t quo;
    mext_pkg::word_t rem;
  } div_reg_t;

  div_reg_t r;
  div_reg_t rin;
  div_reg_t v;

  logic sgn;
  logic a_neg;
  logic b_neg;
  logic [32:0] rem_sh;
  logic [33:0] diff;
  mext_pkg::word_t q_out;
  mext_pkg::word_t r_out;

  always_comb begin
    v = r;
    sgn = 1'b0;
    a_neg = 1'b0;
    b_neg = 1'b0;
    rem_sh = '0;
    diff = '0;
    q_out = '0;
    r_out = '0;
    div_out = '0;
    case (r.counter)
      6'd0: begin
        if (div_in.enable) begin
          sgn = div_in.op.div | div_in.op.rem;
          a_neg = sgn & div_in.rdata1[31];
          b_neg = sgn & div_in.rdata2[31];
          v.op = div_in.op;
          v.early = 1'b0;
          v.counter = 6'd1;
          v.q_neg = a_neg ^ b_neg;
          v.r_neg = a_neg;
          v.quo = a_neg ? -div_in.rdata1 : div_in.rdata1;
          v.divisor = b_neg ? -div_in.rdata2 : div_in.rdata2;
          v.rem = '0;
          if (div_in.rdata2 == '0) begin
            // divide by zero
            v.early = 1'b1;
            v.counter = 6'd32;
            v.q_neg = 1'b0;
            v.r_neg = 1'b0;
            v.quo = '1;
            v.rem = div_in.rdata1;
          end else if (sgn && div_in.rdata1 == 32'h8000_0000 && div_in.rdata2 == '1) begin
            // signed overflow
            v.early = 1'b1;
            v.counter = 6'd32;
            v.q_neg = 1'b0;
            v.r_neg = 1'b0;
            v.quo = div_in.rdata1;
            v.rem = '0;
          end
        end
      end
      6'd33: begin
        q_out = r.q_neg ? -r.quo : r.quo;
        r_out = r.r_neg ? -r.rem : r.rem;
        div_out.ready = 1'b1;
        if (r.op.rem || r.op.remu) begin
          div_out.result = r_out;
        end else begin
          div_out.result = q_out;
        end
        v.counter = 6'd0;
      end
      default: begin
        // one restoring step, quotient bits shift in where the dividend leaves
        if (!r.early) begin
          rem_sh = {r.rem, r.quo[31]};
          diff = {1'b0, rem_sh} - {2'b0, r.divisor};
          v.quo = {r.quo[30:0], ~diff[33]};
          if (diff[33]) begin
            v.rem = rem_sh[31:0];
          end else begin
            v.rem = diff[31:0];
          end
        end
        v.counter = r.counter + 6'd1;
      end
    endcase
    rin = v;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

endmodule

// File: mext_ctrl.sv
`timescale 1ns/1ns

module mext_ctrl (
  input  logic                  rst,
  input  logic                  clk,
  input  logic                  start,
  input  mext_pkg::funct3_t     funct3,
  input  mext_pkg::word_t       rs1,
  input  mext_pkg::word_t       rs2,
  output logic                  busy,
  output logic                  done,
  output mext_pkg::word_t       result,
  output mext_pkg::mul_in_type  mul_in,
  input  mext_pkg::mul_out_type mul_out,
  output mext_pkg::div_in_type  div_in,
  input  mext_pkg::div_out_type div_out
);

  mext_pkg::ctrl_state_t state;
  mext_pkg::mul_op_type mul_op;
  mext_pkg::div_op_type div_op;

  // funct3 to one-hot op flags
  always_comb begin
    mul_op = '0;
    div_op = '0;
    case (funct3)
      mext_pkg::F3_MUL:    mul_op.mul = 1'b1;
      mext_pkg::F3_MULH:   mul_op.mulh = 1'b1;
      mext_pkg::F3_MULHSU: mul_op.mulhsu = 1'b1;
      mext_pkg::F3_MULHU:  mul_op.mulhu = 1'b1;
      mext_pkg::F3_DIV:    div_op.div = 1'b1;
      mext_pkg::F3_DIVU:   div_op.divu = 1'b1;
      mext_pkg::F3_REM:    div_op.rem = 1'b1;
      mext_pkg::F3_REMU:   div_op.remu = 1'b1;
      default: ;
    endcase
  end

  assign busy = (state == mext_pkg::busy_mul) || (state == mext_pkg::busy_div);
  assign done = (state == mext_pkg::finish);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= mext_pkg::idle;
      result <= '0;
      mul_in <= '0;
      div_in <= '0;
    end else begin
      // enable is a single-cycle strobe
      mul_in.enable <= 1'b0;
      div_in.enable <= 1'b0;
      case (state)
        mext_pkg::idle, mext_pkg::finish: begin
          state <= mext_pkg::idle;
          if (start) begin
            if (funct3[2]) begin
              div_in <= '{enable: 1'b1, op: div_op, rdata1: rs1, rdata2: rs2};
              state <= mext_pkg::busy_div;
            end else begin
              mul_in <= '{enable: 1'b1, op: mul_op, rdata1: rs1, rdata2: rs2};
              state <= mext_pkg::busy_mul;
            end
          end
        end
        mext_pkg::busy_mul: begin
          if (mul_out.ready) begin
            result <= mul_out.result;
            state <= mext_pkg::finish;
          end
        end
        mext_pkg::busy_div: begin
          if (div_out.ready) begin
            result <= div_out.result;
            state <= mext_pkg::finish;
          end
        end
        default: state <= mext_pkg::idle;
      endcase
    end
  end

endmodule

// File: mext_unit.sv
`timescale 1ns/1ns

module mext_unit #(
  parameter int PERFORMANCE = 1
) (
  input  logic              rst,
  input  logic              clk,
  input  logic              start,
  input  mext_pkg::funct3_t funct3,
  input  mext_pkg::word_t   rs1,
  input  mext_pkg::word_t   rs2,
  output logic              busy,
  output logic              done,
  output mext_pkg::word_t   result
);

  mext_pkg::mul_in_type  mul_in;
  mext_pkg::mul_out_type mul_out;
  mext_pkg::div_in_type  div_in;
  mext_pkg::div_out_type div_out;

  mext_ctrl mext_ctrl_inst (
    .rst     (rst),
    .clk     (clk),
    .start   (start),
    .funct3  (funct3),
    .rs1     (rs1),
    .rs2     (rs2),
    .busy    (busy),
    .done    (done),
    .result  (result),
    .mul_in  (mul_in),
    .mul_out (mul_out),
    .div_in  (div_in),
    .div_out (div_out)
  );

  mul #(
    .PERFORMANCE (PERFORMANCE)
  ) mul_inst (
    .rst     (rst),
    .clk     (clk),
    .mul_in  (mul_in),
    .mul_out (mul_out)
  );

  div div_inst (
    .rst     (rst),
    .clk     (clk),
    .div_in  (div_in),
    .div_out (div_out)
  );

endmodule

// File: tb_mext_unit.sv
`timescale 1ns/1ns

module tb_mext_unit #(
  parameter int PERFORMANCE = 1
);

  typedef struct packed {
    logic [3:0] funct3;
    mext_pkg::word_t rs1;
    mext_pkg::word_t rs2;
    mext_pkg::word_t expected;
  } vec_t;

  localparam int NUM_VEC = 39;
  localparam int NUM_RAND = 200;
  localparam int CYCLE_LIMIT = (NUM_VEC + NUM_RAND) * 40 + 100;

  logic clk = 1'b0;
  logic rst;
  logic start;
  mext_pkg::funct3_t funct3;
  mext_pkg::word_t rs1;
  mext_pkg::word_t rs2;
  logic busy;
  logic done;
  mext_pkg::word_t result;

  vec_t vectors [NUM_VEC];
  int done_count = 0;
  int cycle_count = 0;
  integer seed;

  mext_unit #(
    .PERFORMANCE (PERFORMANCE)
  ) mext_unit_inst (
    .rst    (rst),
    .clk    (clk),
    .start  (start),
    .funct3 (funct3),
    .rs1    (rs1),
    .rs2    (rs2),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #2 clk = ~clk;

  // done sampled away from the rising edge
  always @(negedge clk) begin
    if (rst && done) begin
      done_count <= done_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input mext_pkg::word_t expected,
                            input mext_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // RISC-V M reference on 64-bit signed arithmetic
  function automatic mext_pkg::word_t model_result(input mext_pkg::funct3_t f3,
                                                   input mext_pkg::word_t a,
                                                   input mext_pkg::word_t b);
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    longint p;
    mext_pkg::word_t q;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    p = 0;
    q = '0;
    case (f3)
      mext_pkg::F3_MUL: begin
        p = sa * sb;
        q = p[31:0];
      end
      mext_pkg::F3_MULH: begin
        p = sa * sb;
        q = p[63:32];
      end
      mext_pkg::F3_MULHSU: begin
        p = sa * ub;
        q = p[63:32];
      end
      mext_pkg::F3_MULHU: begin
        // wraps mod 2^64, upper word still exact
        p = ua * ub;
        q = p[63:32];
      end
      mext_pkg::F3_DIV: begin
        if (b == '0) begin
          q = '1;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = a;
        end else begin
          p = sa / sb;
          q = p[31:0];
        end
      end
      mext_pkg::F3_DIVU: begin
        if (b == '0) begin
          q = '1;
        end else begin
          p = ua / ub;
          q = p[31:0];
        end
      end
      mext_pkg::F3_REM: begin
        if (b == '0) begin
          q = a;
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = '0;
        end else begin
          p = sa % sb;
          q = p[31:0];
        end
      end
      default: begin
        if (b == '0) begin
          q = a;
        end else begin
          p = ua % ub;
          q = p[31:0];
        end
      end
    endcase
    return q;
  endfunction

  // one operation, optionally with an extra start while busy
  task automatic run_op(input string name, input mext_pkg::funct3_t f3,
                        input mext_pkg::word_t a, input mext_pkg::word_t b,
                        input mext_pkg::word_t expected, input logic poke);
    int count_before;
    count_before = done_count;
    start = 1'b1;
    funct3 = f3;
    rs1 = a;
    rs2 = b;
    @(posedge clk);
    #1;
    start = 1'b0;
    check_bit({name, " busy after start"}, 1'b1, busy);
    if (poke) begin
      start = 1'b1;
      funct3 = ~f3;
      rs1 = ~a;
      rs2 = b ^ 32'h5a5a_5a5a;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check_word(name, expected, result);
    check_bit({name, " busy at done"}, 1'b0, busy);
    @(posedge clk);
    #1;
    check_bit({name, " done after one cycle"}, 1'b0, done);
    check_bit({name, " busy after done"}, 1'b0, busy);
    check_word({name, " result held"}, expected, result);
    check_word({name, " done count"}, count_before + 1, done_count);
  endtask

  mext_pkg::word_t a;
  mext_pkg::word_t b;
  mext_pkg::word_t rnd;
  mext_pkg::funct3_t f3;

  initial begin
    rst = 1'b0;
    start = 1'b0;
    funct3 = '0;
    rs1 = '0;
    rs2 = '0;
    seed = 32'hc31dfe82;
    $readmemh("mext_tests.txt", vectors);

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset done", 1'b0, done);
    check_word("reset result", 32'h0, result);

    for (int i = 0; i < NUM_VEC; i++) begin
      run_op($sformatf("vector %0d", i), vectors[i].funct3[2:0], vectors[i].rs1,
             vectors[i].rs2, vectors[i].expected, (i % 4) == 1);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      rnd = $random(seed);
      f3 = rnd[2:0];
      a = $random(seed);
      b = $random(seed);
      // steer some picks into the corner cases
      case (rnd[6:4])
        3'd0: b = '0;
        3'd1: begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end
        3'd2: a = {24'b0, a[7:0]};
        default: ;
      endcase
      run_op($sformatf("random %0d funct3 %0d", i, f3), f3, a, b,
             model_result(f3, a, b), (i % 3) == 0);
    end

    // no late done from an ignored start
    repeat (40) @(posedge clk);
    #1;
    check_bit("busy when idle", 1'b0, busy);
    check_word("total done count", NUM_VEC + NUM_RAND, done_count);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: mext_tests.txt
// funct3 _ rs1 _ rs2 _ expected result, all hex, one operation per line
// funct3: 0 mul 1 mulh 2 mulhsu 3 mulhu 4 div 5 divu 6 rem 7 remu
0_00000003_00000007_00000015
0_ffffffff_ffffffff_00000001
0_80000000_00000002_00000000
0_00012345_00000010_00123450
0_fffffffe_00000005_fffffff6
1_80000000_80000000_40000000
1_ffffffff_ffffffff_00000000
1_ffffffff_00000001_ffffffff
1_7fffffff_7fffffff_3fffffff
1_80000000_7fffffff_c0000000
2_ffffffff_ffffffff_ffffffff
2_00000002_80000000_00000001
2_80000000_ffffffff_80000000
2_7fffffff_ffffffff_7ffffffe
2_fffffffe_00000003_ffffffff
3_ffffffff_ffffffff_fffffffe
3_80000000_00000002_00000001
3_12345678_00000010_00000001
3_00000000_ffffffff_00000000
4_00000014_00000006_00000003
4_ffffffec_00000006_fffffffd
4_00000014_fffffffa_fffffffd
4_ffffffec_fffffffa_00000003
4_00000007_00000000_ffffffff
4_80000000_ffffffff_80000000
5_ffffffec_00000006_2aaaaaa7
5_00000007_00000000_ffffffff
5_80000000_ffffffff_00000000
5_00000064_00000007_0000000e
6_00000014_00000006_00000002
6_ffffffec_00000006_fffffffe
6_00000014_fffffffa_00000002
6_ffffffec_fffffffa_fffffffe
6_00000007_00000000_00000007
6_80000000_ffffffff_00000000
7_ffffffec_00000006_00000002
7_00000007_00000000_00000007
7_80000000_ffffffff_80000000
7_00000064_00000007_00000002

// File: files.f
mext_pkg.sv
mul.sv
div.sv
mext_ctrl.sv
mext_unit.sv
tb_mext_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -GPERFORMANCE=1
TOP      = tb_mext_unit
FILELIST = files.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
